// File: hdl/rv_pkg.sv
package rv_pkg;

    localparam int xlen           = 32;
    localparam int mem_depth_log2 = 8;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_r_type = 7'b0110011;
    localparam logic [6:0] op_i_type = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    typedef enum logic [3:0] {
        add, sub, sll, slt, sltu, xor_op, srl, sra, or_op, and_op
    } alu_op_e;

    typedef enum logic [2:0] {
        not_branch, branch_beq, branch_bne
    } branch_op_e;

    // ------------------------------------------------------------
    // Instruction word views
    // ------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
    } instr_u;

endpackage

// File: hdl/mem_port_if.sv
`timescale 1ns/10ps

interface mem_port_if;
    import rv_pkg::*;

    logic            req;
    logic            we;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] rdata;
    logic            ready;   // One-cycle pulse per request

    modport core   (output req, we, addr, wdata, input rdata, ready);
    modport memory (input req, we, addr, wdata, output rdata, ready);

endinterface

// File: hdl/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic [4:0]              rs1_addr,
    input  logic [4:0]              rs2_addr,
    input  logic [4:0]              rd_addr,
    input  logic                    rd_we,
    input  logic [rv_pkg::xlen-1:0] rd_data,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [1:31];   // x0 has no storage

    // Zero for x0, bypass for a write in flight
    function automatic logic [xlen-1:0] read_reg(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (rd_we && rd_addr == addr) begin
            return rd_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    always_comb begin
        rs1_data = read_reg(rs1_addr);
        rs2_data = read_reg(rs2_addr);
    end

    // A written value lands in storage by the next edge
    a_write_kept: assert property (@(posedge clk) disable iff (!reset_n)
        (rd_we && rd_addr != 5'd0) |=> regs[$past(rd_addr)] == $past(rd_data));

endmodule

// File: hdl/alu_unit.sv
`timescale 1ns/10ps

module alu_unit (
    input  rv_pkg::alu_op_e         op,
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    output logic [rv_pkg::xlen-1:0] result
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];   // Only low five bits shift

    always_comb begin
        case (op)
            add:     result = a + b;
            sub:     result = a - b;
            sll:     result = a << shamt;
            slt:     result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            sltu:    result = {{(xlen-1){1'b0}}, a < b};
            xor_op:  result = a ^ b;
            srl:     result = a >> shamt;
            sra:     result = $unsigned($signed(a) >>> shamt);
            or_op:   result = a | b;
            and_op:  result = a & b;
            default: result = '0;
        endcase
    end

endmodule

// File: hdl/cpu_core.sv
`timescale 1ns/10ps

module cpu_core (
    input  logic                              clk,
    input  logic                              reset_n,
    output logic [rv_pkg::mem_depth_log2-1:0] imem_addr,
    input  logic [31:0]                       imem_data,
    mem_port_if.core                          dmem,
    output logic                              retire_valid,
    output logic [4:0]                        retire_rd,
    output logic [rv_pkg::xlen-1:0]           retire_data
);
    import rv_pkg::*;

    logic [xlen-1:0] pc;
    logic            ifid_valid;
    logic [xlen-1:0] ifid_pc;
    instr_u          ifid_ir;

    logic            idex_valid, idex_reg_write, idex_mem_read, idex_mem_write, idex_alu_src;
    logic [xlen-1:0] idex_pc, idex_imm, idex_rs1_data, idex_rs2_data;
    logic [4:0]      idex_rs1, idex_rs2, idex_rd;
    alu_op_e         idex_alu_op;
    branch_op_e      idex_branch_op;

    logic            exmem_valid, exmem_reg_write, exmem_mem_read, exmem_mem_write;
    logic [xlen-1:0] exmem_alu_out, exmem_store_data, exmem_branch_target;
    logic [4:0]      exmem_rd;
    branch_op_e      exmem_branch_op;

    logic            memwb_valid, memwb_reg_write, memwb_mem_read;
    logic [xlen-1:0] memwb_alu_out, memwb_load_data, wb_data;
    logic [4:0]      memwb_rd;
    logic            wb_we;

    // Hazard controls
    logic freeze, load_use, branch_taken;

    // ------------------------------------------------------------
    // Fetch and decode
    // ------------------------------------------------------------
    logic [6:0]      id_opcode;
    logic [4:0]      id_rs1, id_rs2;
    logic [xlen-1:0] id_rs1_data, id_rs2_data, id_imm;
    logic            id_legal, id_reg_write, id_mem_read, id_mem_write, id_alu_src, id_uses_rs2;
    alu_op_e         id_alu_op;
    branch_op_e      id_branch_op;

    assign imem_addr = pc[mem_depth_log2+1:2];   // Word index
    assign id_opcode = ifid_ir.r_fmt.opcode;
    assign id_rs1    = ifid_ir.r_fmt.rs1;
    assign id_rs2    = ifid_ir.r_fmt.rs2;

    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? sub : add;
            3'b001:  return sll;
            3'b010:  return slt;
            3'b011:  return sltu;
            3'b100:  return xor_op;
            3'b101:  return alt ? sra : srl;
            3'b110:  return or_op;
            default: return and_op;
        endcase
    endfunction

    register_file u_regfile (
        .clk(clk), .reset_n(reset_n),
        .rs1_addr(id_rs1), .rs2_addr(id_rs2),
        .rd_addr(memwb_rd), .rd_we(wb_we), .rd_data(wb_data),
        .rs1_data(id_rs1_data), .rs2_data(id_rs2_data)
    );

    always_comb begin
        id_legal     = 1'b0;
        id_reg_write = 1'b0;
        id_mem_read  = 1'b0;
        id_mem_write = 1'b0;
        id_alu_src   = 1'b0;
        id_uses_rs2  = 1'b0;
        id_alu_op    = add;
        id_branch_op = not_branch;
        id_imm       = {{20{ifid_ir.i_fmt.imm_11_0[11]}}, ifid_ir.i_fmt.imm_11_0};
        case (id_opcode)
            op_r_type: begin
                id_legal     = 1'b1;
                id_reg_write = 1'b1;
                id_uses_rs2  = 1'b1;
                id_alu_op    = alu_from_funct(ifid_ir.r_fmt.funct3, ifid_ir.r_fmt.funct7[5]);
            end
            op_i_type: begin
                id_legal     = 1'b1;
                id_reg_write = 1'b1;
                id_alu_src   = 1'b1;
                // funct7 bit only selects srai, addi has no subtract form
                id_alu_op    = alu_from_funct(ifid_ir.i_fmt.funct3,
                    ifid_ir.i_fmt.funct3 == 3'b101 && ifid_ir.r_fmt.funct7[5]);
            end
            op_load: begin
                id_legal     = ifid_ir.i_fmt.funct3 == 3'b010;   // LW only
                id_reg_write = 1'b1;
                id_mem_read  = 1'b1;
                id_alu_src   = 1'b1;
            end
            op_store: begin
                id_legal     = ifid_ir.s_fmt.funct3 == 3'b010;   // SW only
                id_mem_write = 1'b1;
                id_alu_src   = 1'b1;
                id_uses_rs2  = 1'b1;
                id_imm       = {{20{ifid_ir.s_fmt.imm_11_5[6]}}, ifid_ir.s_fmt.imm_11_5,
                                ifid_ir.s_fmt.imm_4_0};
            end
            op_branch: begin
                id_legal     = ifid_ir.b_fmt.funct3 == 3'b000 || ifid_ir.b_fmt.funct3 == 3'b001;
                id_uses_rs2  = 1'b1;
                id_alu_op    = sub;   // Compare by subtraction
                id_branch_op = ifid_ir.b_fmt.funct3[0] ? branch_bne : branch_beq;
                id_imm       = {{19{ifid_ir.b_fmt.imm_12}}, ifid_ir.b_fmt.imm_12,
                                ifid_ir.b_fmt.imm_11, ifid_ir.b_fmt.imm_10_5,
                                ifid_ir.b_fmt.imm_4_1, 1'b0};
            end
            default: ;   // Unknown word becomes a bubble
        endcase
    end

    // ------------------------------------------------------------
    // Execute with forwarding
    // ------------------------------------------------------------
    logic [xlen-1:0] fwd_rs1, fwd_rs2, alu_b, alu_out;

    always_comb begin
        if (exmem_valid && exmem_reg_write && exmem_rd != 5'd0 && exmem_rd == idex_rs1) begin
            fwd_rs1 = exmem_alu_out;
        end else if (memwb_valid && memwb_reg_write && memwb_rd != 5'd0 &&
                     memwb_rd == idex_rs1) begin
            fwd_rs1 = wb_data;
        end else begin
            fwd_rs1 = idex_rs1_data;
        end
        if (exmem_valid && exmem_reg_write && exmem_rd != 5'd0 && exmem_rd == idex_rs2) begin
            fwd_rs2 = exmem_alu_out;
        end else if (memwb_valid && memwb_reg_write && memwb_rd != 5'd0 &&
                     memwb_rd == idex_rs2) begin
            fwd_rs2 = wb_data;
        end else begin
            fwd_rs2 = idex_rs2_data;
        end
    end

    assign alu_b = idex_alu_src ? idex_imm : fwd_rs2;

    alu_unit u_alu (.op(idex_alu_op), .a(fwd_rs1), .b(alu_b), .result(alu_out));

    // ------------------------------------------------------------
    // Memory, writeback and hazards
    // ------------------------------------------------------------
    assign dmem.req   = exmem_valid && (exmem_mem_read || exmem_mem_write);
    assign dmem.we    = exmem_valid && exmem_mem_write;
    assign dmem.addr  = exmem_alu_out;
    assign dmem.wdata = exmem_store_data;

    assign freeze       = dmem.req && !dmem.ready;
    assign branch_taken = exmem_valid &&
        ((exmem_branch_op == branch_beq && exmem_alu_out == '0) ||
         (exmem_branch_op == branch_bne && exmem_alu_out != '0));
    assign load_use     = idex_valid && idex_mem_read && idex_rd != 5'd0 && ifid_valid &&
        (idex_rd == id_rs1 || (id_uses_rs2 && idex_rd == id_rs2));

    assign wb_data      = memwb_mem_read ? memwb_load_data : memwb_alu_out;
    assign wb_we        = memwb_valid && memwb_reg_write && !freeze;
    assign retire_valid = wb_we && memwb_rd != 5'd0;
    assign retire_rd    = memwb_rd;
    assign retire_data  = wb_data;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc          <= '0;
            ifid_valid  <= 1'b0;
            idex_valid  <= 1'b0;
            exmem_valid <= 1'b0;
            memwb_valid <= 1'b0;
        end else if (!freeze) begin
            memwb_valid <= exmem_valid;
            exmem_valid <= idex_valid && !branch_taken;
            idex_valid  <= ifid_valid && id_legal && !branch_taken && !load_use;
            if (branch_taken) begin
                pc         <= exmem_branch_target;
                ifid_valid <= 1'b0;
            end else if (!load_use) begin
                pc         <= pc + xlen'(4);
                ifid_valid <= 1'b1;
            end
        end
    end

    // Payload, qualified by the valid bits
    always_ff @(posedge clk) begin
        if (!freeze) begin
            if (!load_use) begin
                ifid_pc <= pc;
                ifid_ir <= imem_data;
            end
            idex_pc             <= ifid_pc;
            idex_rs1            <= id_rs1;
            idex_rs2            <= id_rs2;
            idex_rd             <= ifid_ir.r_fmt.rd;
            idex_imm            <= id_imm;
            idex_rs1_data       <= id_rs1_data;
            idex_rs2_data       <= id_rs2_data;
            idex_alu_op         <= id_alu_op;
            idex_alu_src        <= id_alu_src;
            idex_reg_write      <= id_reg_write;
            idex_mem_read       <= id_mem_read;
            idex_mem_write      <= id_mem_write;
            idex_branch_op      <= id_branch_op;
            exmem_alu_out       <= alu_out;
            exmem_store_data    <= fwd_rs2;
            exmem_branch_target <= idex_pc + idex_imm;
            exmem_rd            <= idex_rd;
            exmem_reg_write     <= idex_reg_write;
            exmem_mem_read      <= idex_mem_read;
            exmem_mem_write     <= idex_mem_write;
            exmem_branch_op     <= idex_branch_op;
            memwb_alu_out       <= exmem_alu_out;
            memwb_load_data     <= dmem.rdata;   // Valid on the ready cycle
            memwb_rd            <= exmem_rd;
            memwb_reg_write     <= exmem_reg_write;
            memwb_mem_read      <= exmem_mem_read;
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (!reset_n)
        dmem.req && !dmem.ready |=> dmem.req && $stable(dmem.we) &&
            $stable(dmem.addr) && $stable(dmem.wdata));

    // A load-use stall lasts a single cycle
    a_stall_once: assert property (@(posedge clk) disable iff (!reset_n)
        (load_use && !freeze && !branch_taken) |=> !load_use);

endmodule

// File: hdl/instr_memory.sv
`timescale 1ns/10ps

module instr_memory (
    input  logic                              clk,
    input  logic                              load_we,
    input  logic [rv_pkg::mem_depth_log2-1:0] load_addr,
    input  logic [31:0]                       load_data,
    input  logic [rv_pkg::mem_depth_log2-1:0] fetch_addr,
    output logic [31:0]                       fetch_data
);
    import rv_pkg::*;

    // Unloaded words stay zero and decode as bubbles
    logic [31:0] mem [2**mem_depth_log2] = '{default: '0};

    always_ff @(posedge clk) begin
        if (load_we) begin
            mem[load_addr] <= load_data;
        end
    end

    assign fetch_data = mem[fetch_addr];   // Combinational fetch

endmodule

// File: hdl/data_memory.sv
`timescale 1ns/10ps

module data_memory (
    input logic        clk,
    input logic        reset_n,
    mem_port_if.memory port
);
    import rv_pkg::*;

    logic [xlen-1:0]           mem [2**mem_depth_log2] = '{default: '0};
    logic [mem_depth_log2-1:0] index;
    logic                      busy;   // Request accepted, answer due

    assign index      = port.addr[mem_depth_log2+1:2];
    assign port.ready = busy;

    // ------------------------------------------------------------
    // One ready pulse per request
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy <= 1'b0;
        end else begin
            busy <= port.req && !busy;
        end
    end

    // Access happens on the first request cycle
    always_ff @(posedge clk) begin
        if (port.req && !busy) begin
            if (port.we) begin
                mem[index] <= port.wdata;
            end
            port.rdata <= mem[index];
        end
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (!reset_n)
        port.req |-> port.addr[1:0] == 2'b00);

endmodule

// File: hdl/cpu_top.sv
`timescale 1ns/10ps

module cpu_top (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic                              load_we,
    input  logic [rv_pkg::mem_depth_log2-1:0] load_addr,
    input  logic [31:0]                       load_data,
    output logic                              retire_valid,
    output logic [4:0]                        retire_rd,
    output logic [rv_pkg::xlen-1:0]           retire_data
);
    import rv_pkg::*;

    logic [mem_depth_log2-1:0] imem_addr;
    logic [31:0]               imem_data;

    mem_port_if dmem_bus ();

    cpu_core u_core (
        .clk          (clk),
        .reset_n      (reset_n),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .dmem         (dmem_bus.core),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    // Program store, loaded while the core is in reset
    instr_memory u_imem (
        .clk        (clk),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .fetch_addr (imem_addr),
        .fetch_data (imem_data)
    );

    data_memory u_dmem (
        .clk     (clk),
        .reset_n (reset_n),
        .port    (dmem_bus.memory)
    );

endmodule

// File: sim/tb_cpu_top.sv
`timescale 1ns/10ps

module tb_cpu_top;
    import rv_pkg::*;

    localparam int retire_timeout = 2000;   // Cycles per awaited retirement

    logic                      clk;
    logic                      reset_n;
    logic                      load_we;
    logic [mem_depth_log2-1:0] load_addr;
    logic [31:0]               load_data;
    logic                      retire_valid;
    logic [4:0]                retire_rd;
    logic [xlen-1:0]           retire_data;

    // Program image and the test each word belongs to
    logic [31:0] prog[$];
    int          prog_test[$];
    int          cur_test;
    int          seed = 80;

    // Expected register writes in program order
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_data[$];
    int          exp_test[$];

    int    errors [1:7] = '{default: 0};
    string test_name [1:7] = '{"R-type ALU", "I-type ALU", "forwarding", "load and store",
                               "branches", "x0 writes", "idle after end"};
    int    n_pass = 0;
    int    n_fail = 0;
    bit    timed_out = 1'b0;
    bit    check_done = 1'b0;

    localparam logic [2:0] r_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5,
                                         3'd6, 3'd7};

    cpu_top dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .load_we      (load_we),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Assembler
    // ------------------------------------------------------------
    task automatic put_word(input instr_u w);
        prog.push_back(w);
        prog_test.push_back(cur_test);
    endtask

    task automatic r_instr(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] dst,
                           input logic [4:0] src1, input logic [4:0] src2);
        instr_u w;
        w.r_fmt = '{funct7: f7, rs2: src2, rs1: src1, funct3: f3, rd: dst, opcode: op_r_type};
        put_word(w);
    endtask

    task automatic i_instr(input logic [6:0] opc, input logic [2:0] f3, input logic [4:0] dst,
                           input logic [4:0] src1, input logic [11:0] imm);
        instr_u w;
        w.i_fmt = '{imm_11_0: imm, rs1: src1, funct3: f3, rd: dst, opcode: opc};
        put_word(w);
    endtask

    task automatic store_instr(input logic [4:0] src2, input logic [4:0] base,
                               input logic [11:0] imm);
        instr_u w;
        w.s_fmt = '{imm_11_5: imm[11:5], rs2: src2, rs1: base, funct3: 3'd2,
                    imm_4_0: imm[4:0], opcode: op_store};
        put_word(w);
    endtask

    task automatic branch_instr(input logic [2:0] f3, input logic [4:0] src1,
                                input logic [4:0] src2, input logic [12:0] off);
        instr_u w;
        w.b_fmt = '{imm_12: off[12], imm_10_5: off[10:5], rs2: src2, rs1: src1, funct3: f3,
                    imm_4_1: off[4:1], imm_11: off[11], opcode: op_branch};
        put_word(w);
    endtask

    task automatic build_program();
        cur_test = 1;
        for (int r = 0; r < 2; r++) begin
            i_instr(op_i_type, 3'd0, 5'd1, 5'd0, 12'($random(seed)));
            i_instr(op_i_type, 3'd0, 5'd2, 5'd0, 12'($random(seed)));
            for (int k = 0; k < 10; k++) begin
                r_instr((k == 1 || k == 7) ? 7'h20 : 7'h00, r_f3[k], 5'(k + 3), 5'd1, 5'd2);
            end
        end
        cur_test = 2;
        i_instr(op_i_type, 3'd0, 5'd1, 5'd0, 12'($random(seed)) | 12'h800);   // Negative base
        i_instr(op_i_type, 3'd0, 5'd3, 5'd1, 12'($random(seed)) | 12'h800);
        i_instr(op_i_type, 3'd2, 5'd4, 5'd1, 12'($random(seed)));
        i_instr(op_i_type, 3'd3, 5'd5, 5'd1, 12'($random(seed)));
        i_instr(op_i_type, 3'd4, 5'd6, 5'd1, 12'($random(seed)));
        i_instr(op_i_type, 3'd6, 5'd7, 5'd1, 12'($random(seed)));
        i_instr(op_i_type, 3'd7, 5'd8, 5'd1, 12'($random(seed)));
        i_instr(op_i_type, 3'd1, 5'd9, 5'd1, {7'h00, 5'($random(seed))});
        i_instr(op_i_type, 3'd5, 5'd10, 5'd1, {7'h00, 5'($random(seed))});
        i_instr(op_i_type, 3'd5, 5'd11, 5'd1, {7'h20, 5'($random(seed))});   // srai
        cur_test = 3;
        i_instr(op_i_type, 3'd0, 5'd14, 5'd0, 12'($random(seed)));
        i_instr(op_i_type, 3'd0, 5'd15, 5'd14, 12'($random(seed)));
        r_instr(7'h00, 3'd0, 5'd16, 5'd14, 5'd15);
        r_instr(7'h20, 3'd0, 5'd17, 5'd16, 5'd14);
        i_instr(op_i_type, 3'd0, 5'd18, 5'd0, 12'd1);
        i_instr(op_i_type, 3'd0, 5'd18, 5'd0, 12'd2);
        r_instr(7'h00, 3'd0, 5'd19, 5'd18, 5'd18);   // Nearer x18 must win
        r_instr(7'h00, 3'd4, 5'd19, 5'd19, 5'd17);
        cur_test = 4;
        i_instr(op_i_type, 3'd0, 5'd20, 5'd0, 12'($random(seed)) & 12'h3f8);
        i_instr(op_i_type, 3'd0, 5'd21, 5'd0, 12'($random(seed)));
        store_instr(5'd21, 5'd20, 12'd0);
        i_instr(op_load, 3'd2, 5'd22, 5'd20, 12'd0);
        r_instr(7'h00, 3'd0, 5'd23, 5'd22, 5'd21);   // Load-use
        store_instr(5'd23, 5'd20, 12'd4);
        i_instr(op_load, 3'd2, 5'd24, 5'd20, 12'd4);
        i_instr(op_i_type, 3'd0, 5'd25, 5'd24, 12'd1);
        i_instr(op_i_type, 3'd0, 5'd20, 5'd20, 12'd8);
        i_instr(op_load, 3'd2, 5'd25, 5'd20, 12'hffc);   // Negative offset
        cur_test = 5;
        i_instr(op_i_type, 3'd0, 5'd26, 5'd0, 12'($random(seed)) | 12'h001);
        i_instr(op_i_type, 3'd0, 5'd27, 5'd26, 12'd0);
        branch_instr(3'd0, 5'd26, 5'd27, 13'd12);    // Taken beq
        i_instr(op_i_type, 3'd0, 5'd28, 5'd0, 12'd1);
        i_instr(op_i_type, 3'd0, 5'd29, 5'd0, 12'd2);
        i_instr(op_i_type, 3'd0, 5'd30, 5'd0, 12'd3);
        branch_instr(3'd1, 5'd26, 5'd27, 13'd12);    // Not taken bne
        i_instr(op_i_type, 3'd0, 5'd28, 5'd0, 12'd4);
        i_instr(op_i_type, 3'd0, 5'd29, 5'd0, 12'd5);
        branch_instr(3'd1, 5'd26, 5'd0, 13'd12);
        i_instr(op_i_type, 3'd0, 5'd28, 5'd0, 12'd6);
        i_instr(op_i_type, 3'd0, 5'd29, 5'd0, 12'd7);
        branch_instr(3'd0, 5'd26, 5'd0, 13'd8);
        i_instr(op_i_type, 3'd0, 5'd30, 5'd0, 12'd8);
        cur_test = 6;
        i_instr(op_i_type, 3'd0, 5'd0, 5'd0, 12'($random(seed)));
        r_instr(7'h00, 3'd0, 5'd0, 5'd26, 5'd27);
        i_instr(op_i_type, 3'd0, 5'd31, 5'd0, 12'd5);
        r_instr(7'h00, 3'd0, 5'd31, 5'd0, 5'd31);
        i_instr(op_load, 3'd2, 5'd0, 5'd20, 12'd0);
        r_instr(7'h00, 3'd0, 5'd31, 5'd0, 5'd0);
        branch_instr(3'd0, 5'd0, 5'd0, 13'd0);       // Park on a self loop
    endtask

    // ------------------------------------------------------------
    // Reference model, one instruction at a time
    // ------------------------------------------------------------
    function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void run_reference();
        logic [31:0] regs [32];
        logic [31:0] mem [256];
        instr_u      w;
        logic [31:0] a, b, imm, res, addr;
        int          pc, steps, off;
        bit          writes, done;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
        pc = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 1000) begin
            if (pc / 4 >= prog.size()) begin
                done = 1'b1;
            end else begin
                w = prog[pc / 4];
                a = regs[w.r_fmt.rs1];
                b = regs[w.r_fmt.rs2];
                imm = {{20{w.i_fmt.imm_11_0[11]}}, w.i_fmt.imm_11_0};
                writes = 1'b1;
                res = '0;
                case (w.r_fmt.opcode)
                    op_r_type: res = alu_result(w.r_fmt.funct3, w.r_fmt.funct7[5], a, b);
                    op_i_type: res = alu_result(w.i_fmt.funct3,
                        w.i_fmt.funct3 == 3'd5 && w.i_fmt.imm_11_0[10], a, imm);
                    op_load: begin
                        addr = a + imm;
                        res = mem[addr[9:2]];
                    end
                    op_store: begin
                        addr = a + {{20{w.s_fmt.imm_11_5[6]}}, w.s_fmt.imm_11_5, w.s_fmt.imm_4_0};
                        mem[addr[9:2]] = b;
                        writes = 1'b0;
                    end
                    op_branch: begin
                        writes = 1'b0;
                        if ((a == b) != w.b_fmt.funct3[0]) begin
                            off = int'($signed({w.b_fmt.imm_12, w.b_fmt.imm_11,
                                w.b_fmt.imm_10_5, w.b_fmt.imm_4_1, 1'b0}));
                            done = (off == 0);
                            pc = pc + off - 4;
                        end
                    end
                    default: writes = 1'b0;
                endcase
                if (writes && w.r_fmt.rd != 5'd0) begin
                    regs[w.r_fmt.rd] = res;
                    exp_rd.push_back(w.r_fmt.rd);
                    exp_data.push_back(res);
                    exp_test.push_back(prog_test[pc / 4]);
                end
                pc = pc + 4;
                steps++;
            end
        end
    endfunction

    task automatic report_test(input int t);
        if (errors[t] == 0) begin
            $display("Test %0d (%s): passed", t, test_name[t]);
            n_pass++;
        end else begin
            $display("Test %0d (%s): failed with %0d errors", t, test_name[t], errors[t]);
            n_fail++;
        end
    endtask

    // ------------------------------------------------------------
    // Retire checker
    // ------------------------------------------------------------
    initial begin : retire_check
        int idx;
        int waited;
        int t;
        idx = 0;
        waited = 0;
        while (reset_n !== 1'b1 && waited < retire_timeout) begin
            @(negedge clk);
            waited++;
        end
        while (idx < exp_rd.size() && !timed_out) begin
            waited = 0;
            @(negedge clk);   // Outputs settled mid-cycle
            while (retire_valid !== 1'b1 && waited < retire_timeout) begin
                @(negedge clk);
                waited++;
            end
            t = exp_test[idx];
            if (retire_valid !== 1'b1) begin
                $display("Timeout: the write of x%0d (entry %0d, test %0d) never retired",
                         exp_rd[idx], idx, t);
                errors[t]++;
                timed_out = 1'b1;
            end else begin
                if (retire_rd !== exp_rd[idx]) begin
                    $display("Fail at %0d ns: retire_rd expected x%0d, got x%0d",
                             $time, exp_rd[idx], retire_rd);
                    errors[t]++;
                end
                if (retire_data !== exp_data[idx]) begin
                    $display("Fail at %0d ns: retire_data expected 0x%08h, got 0x%08h",
                             $time, exp_data[idx], retire_data);
                    errors[t]++;
                end
            end
            if (timed_out || idx == exp_rd.size() - 1 || exp_test[idx + 1] != t) begin
                report_test(t);
            end
            idx++;
        end
        if (!timed_out) begin
            for (int c = 0; c < 50; c++) begin
                @(negedge clk);
                if (retire_valid === 1'b1) begin
                    $display("Unexpected retirement of x%0d at %0d ns after the program ended",
                             retire_rd, $time);
                    errors[7]++;
                end
            end
            report_test(7);
        end
        check_done = 1'b1;
    end

    // ------------------------------------------------------------
    // Load, reset and final report
    // ------------------------------------------------------------
    initial begin : main_flow
        int waited;
        int limit;
        reset_n   = 1'b0;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        build_program();
        run_reference();
        // Core held in reset while the program loads
        for (int k = 0; k < prog.size(); k++) begin
            @(posedge clk);
            #1;
            load_we   = 1'b1;
            load_addr = mem_depth_log2'(k);
            load_data = prog[k];
        end
        @(posedge clk);
        #1 load_we = 1'b0;
        repeat (4) @(posedge clk);
        #1 reset_n = 1'b1;
        waited = 0;
        limit = retire_timeout * (exp_rd.size() + 2);
        while (!check_done && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!check_done) begin
            $display("The retire checker did not finish within %0d cycles", limit);
        end
        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (check_done && !timed_out && n_fail == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
hdl/rv_pkg.sv
hdl/mem_port_if.sv
hdl/register_file.sv
hdl/alu_unit.sv
hdl/cpu_core.sv
hdl/instr_memory.sv
hdl/data_memory.sv
hdl/cpu_top.sv
sim/tb_cpu_top.sv

// File: Makefile
OBJ_DIR = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f vlog.f --top-module tb_cpu_top -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vtb_cpu_top > sim.log 2>&1; cat sim.log
	grep -q '>>> PASS' sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
